// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_fee_reg
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/fee_cmd_pkg.sv ====
// Command sequencer states, dwell times and the request/response records
// passed between the sequencer, the register banks and the reply stage.
package fee_cmd_pkg;

	typedef enum logic [2:0] {
		CMD_WAIT,
		CMD_EXEC,
		CMD_READ,
		CMD_WRITE,
		CMD_ACK
	} cmd_state_e;

	// Dwell counter and the time spent in the busy and acknowledge states
	typedef logic [3:0] dwell_t;
	localparam dwell_t BUSY_CYCLES = 4'd11;
	localparam dwell_t ACK_CYCLES = 4'd2;

	// Strobes are single-cycle, the other fields hold for the whole command
	typedef struct packed {
		logic rd;
		logic wr;
		fee_reg_pkg::addr_t addr;
		fee_reg_pkg::word_t wdata;
		logic rw;
	} cmd_req_t;

	typedef struct packed {
		logic hit;
		fee_reg_pkg::word_t rdata;
	} bank_resp_t;

endpackage

// ==== source/fee_cmd_reply.sv ====
// Reply stage. Loads cmd_tx from whichever bank owns a read, and records the
// last command that no bank accepted in the error word.
`timescale 1ns/1ps

module fee_cmd_reply (
	input  logic                     clk_40m,
	input  logic                     reset,
	input  fee_cmd_pkg::cmd_req_t    req,
	input  fee_cmd_pkg::bank_resp_t  cfg_resp,
	input  fee_cmd_pkg::bank_resp_t  hv_resp,
	input  fee_cmd_pkg::bank_resp_t  mon_resp,
	output fee_reg_pkg::word_t       cmd_tx,
	output fee_reg_pkg::word_t       err_fpga_cmd,
	output logic                     err_clr
);

	logic own_rd;
	logic own_wr;
	logic any_hit;
	logic cmd_err;

	// Error word readback and its clear command live here
	assign own_rd = req.rd && (req.addr == fee_reg_pkg::ADDR_ERR);
	assign own_wr = req.wr && (req.addr == fee_reg_pkg::ADDR_ERR_CLR);
	assign any_hit = cfg_resp.hit || hv_resp.hit || mon_resp.hit || own_rd || own_wr;
	assign cmd_err = (req.rd || req.wr) && !any_hit;

	always_ff @(posedge clk_40m) begin
		if (reset) begin
			cmd_tx <= '0;
			err_fpga_cmd <= '0;
			err_clr <= 1'b0;
		end else begin
			err_clr <= own_wr;
			// Unowned reads leave cmd_tx as it was
			if (cfg_resp.hit && req.rd) begin
				cmd_tx <= cfg_resp.rdata;
			end else if (hv_resp.hit && req.rd) begin
				cmd_tx <= hv_resp.rdata;
			end else if (mon_resp.hit) begin
				cmd_tx <= mon_resp.rdata;
			end else if (own_rd) begin
				cmd_tx <= err_fpga_cmd;
			end
			if (own_wr) begin
				err_fpga_cmd <= '0;
			end else if (cmd_err) begin
				err_fpga_cmd <= {req.rw, 1'b1, 6'b0, req.addr};
			end
		end
	end

	a_one_owner: assert property (@(posedge clk_40m) disable iff (reset)
		$onehot0({cfg_resp.hit, hv_resp.hit, mon_resp.hit, own_rd, own_wr}));

endmodule

// ==== source/fee_cmd_sequencer.sv ====
// Slow-control command FSM. Latches a command on cmd_exec, issues one read or
// write strobe, waits the busy time and then holds cmd_ack for the ack time.
`timescale 1ns/1ps

module fee_cmd_sequencer (
	input  logic                   clk_40m,
	input  logic                   reset,
	input  logic                   cmd_exec,
	input  logic                   cmd_rw,
	input  fee_reg_pkg::addr_t     cmd_addr,
	input  fee_reg_pkg::word_t     cmd_rx,
	output logic                   cmd_ack,
	output fee_cmd_pkg::cmd_req_t  req
);

	fee_cmd_pkg::cmd_state_e state;
	fee_cmd_pkg::dwell_t dwell;

	assign cmd_ack = (state == fee_cmd_pkg::CMD_ACK);

	always_ff @(posedge clk_40m) begin
		if (reset) begin
			state <= fee_cmd_pkg::CMD_WAIT;
			dwell <= '0;
			req.rd <= 1'b0;
			req.wr <= 1'b0;
		end else begin
			// Strobes only ever last one cycle
			req.rd <= 1'b0;
			req.wr <= 1'b0;
			case (state)
				fee_cmd_pkg::CMD_WAIT: begin
					dwell <= '0;
					if (cmd_exec) begin
						req.addr <= cmd_addr;
						req.wdata <= cmd_rx;
						req.rw <= cmd_rw;
						state <= fee_cmd_pkg::CMD_EXEC;
					end
				end
				fee_cmd_pkg::CMD_EXEC: begin
					req.rd <= req.rw;
					req.wr <= !req.rw;
					state <= req.rw ? fee_cmd_pkg::CMD_READ : fee_cmd_pkg::CMD_WRITE;
				end
				fee_cmd_pkg::CMD_READ, fee_cmd_pkg::CMD_WRITE: begin
					if (dwell == fee_cmd_pkg::BUSY_CYCLES - 1'b1) begin
						dwell <= '0;
						state <= fee_cmd_pkg::CMD_ACK;
					end else begin
						dwell <= dwell + 1'b1;
					end
				end
				fee_cmd_pkg::CMD_ACK: begin
					if (dwell == fee_cmd_pkg::ACK_CYCLES - 1'b1) begin
						dwell <= '0;
						state <= fee_cmd_pkg::CMD_WAIT;
					end else begin
						dwell <= dwell + 1'b1;
					end
				end
				default: state <= fee_cmd_pkg::CMD_WAIT;
			endcase
		end
	end

	a_one_strobe: assert property (@(posedge clk_40m) disable iff (reset)
		!(req.rd && req.wr));

	// Host sees a fixed-length acknowledge
	a_ack_len: assert property (@(posedge clk_40m) disable iff (reset)
		$rose(cmd_ack) |-> cmd_ack [*fee_cmd_pkg::ACK_CYCLES] ##1 !cmd_ack);

endmodule

// ==== source/fee_config_regs.sv ====
// Configuration bank: readout enables, card address, temperature threshold,
// readout-chip channel mask and the counter-reset / HV-update controls.
`timescale 1ns/1ps

module fee_config_regs (
	input  logic                     clk_40m,
	input  logic                     reset,
	input  fee_cmd_pkg::cmd_req_t    req,
	output fee_cmd_pkg::bank_resp_t  resp,
	output logic [2:0]               reg_en,
	output logic                     lgsen,
	output logic [4:0]               fee_addr,
	output fee_reg_pkg::temp_th_t    toti_h,
	output fee_reg_pkg::temp_th_t    thyst_h,
	output logic [31:0]              channel_mask,
	output logic                     cnt_reset_pulse,
	output logic                     hv_update
);

	logic rd_own;
	logic wr_own;
	fee_reg_pkg::word_t rd_data;

	// Address decode for both directions
	always_comb begin
		rd_own = 1'b1;
		wr_own = 1'b1;
		rd_data = '0;
		case (req.addr)
			fee_reg_pkg::ADDR_REG_EN: rd_data = fee_reg_pkg::word_t'(reg_en);
			fee_reg_pkg::ADDR_LGSEN: rd_data = fee_reg_pkg::word_t'(lgsen);
			fee_reg_pkg::ADDR_FEE_ADDR: rd_data = fee_reg_pkg::word_t'(fee_addr);
			fee_reg_pkg::ADDR_TOTI: rd_data = fee_reg_pkg::word_t'(toti_h);
			fee_reg_pkg::ADDR_MASK_LO: rd_data = channel_mask[15:0];
			fee_reg_pkg::ADDR_MASK_HI: rd_data = channel_mask[31:16];
			// Write-only controls
			fee_reg_pkg::ADDR_CNT_RESET, fee_reg_pkg::ADDR_HV_UPDATE: rd_own = 1'b0;
			default: begin
				rd_own = 1'b0;
				wr_own = 1'b0;
			end
		endcase
	end

	assign resp.hit = (req.rd && rd_own) || (req.wr && wr_own);
	assign resp.rdata = rd_data;

	always_ff @(posedge clk_40m) begin
		if (reset) begin
			reg_en <= fee_reg_pkg::REG_EN_DEFAULT;
			lgsen <= fee_reg_pkg::LGSEN_DEFAULT;
			fee_addr <= '0;
			toti_h <= fee_reg_pkg::TOTI_DEFAULT;
			thyst_h <= fee_reg_pkg::TOTI_DEFAULT - fee_reg_pkg::THYST_OFFSET;
			channel_mask <= '0;
			// Counters get cleared on the way out of reset
			cnt_reset_pulse <= 1'b1;
			hv_update <= 1'b0;
		end else begin
			thyst_h <= toti_h - fee_reg_pkg::THYST_OFFSET;
			cnt_reset_pulse <= 1'b0;
			if (req.wr) begin
				case (req.addr)
					fee_reg_pkg::ADDR_REG_EN: reg_en <= req.wdata[2:0];
					fee_reg_pkg::ADDR_LGSEN: lgsen <= req.wdata[0];
					fee_reg_pkg::ADDR_FEE_ADDR: fee_addr <= req.wdata[4:0];
					fee_reg_pkg::ADDR_TOTI: toti_h <= req.wdata[7:0];
					fee_reg_pkg::ADDR_MASK_LO: channel_mask[15:0] <= req.wdata;
					fee_reg_pkg::ADDR_MASK_HI: channel_mask[31:16] <= req.wdata;
					fee_reg_pkg::ADDR_CNT_RESET: cnt_reset_pulse <= 1'b1;
					// Sticky until the next reset
					fee_reg_pkg::ADDR_HV_UPDATE: hv_update <= 1'b1;
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== source/fee_hv_bank.sv ====
// Bias setpoint bank. Holds the 32 HV DAC codes and presents four of them per
// step of the external DAC channel counter.
`timescale 1ns/1ps

module fee_hv_bank (
	input  logic                     clk_40m,
	input  logic                     reset,
	input  fee_cmd_pkg::cmd_req_t    req,
	input  logic [2:0]               dac_cnt,
	output fee_cmd_pkg::bank_resp_t  resp,
	output fee_reg_pkg::hv_code_t    dac_data [fee_reg_pkg::HV_LANES]
);

	fee_reg_pkg::hv_code_t setpoint [fee_reg_pkg::HV_REGS];
	fee_reg_pkg::addr_t hv_off;
	logic [fee_reg_pkg::HV_IDX_W-1:0] hv_idx;
	logic own;

	// Addresses below the base wrap to a large offset and fall outside the bank
	assign hv_off = req.addr - fee_reg_pkg::ADDR_HV_BASE;
	assign own = hv_off < fee_reg_pkg::addr_t'(fee_reg_pkg::HV_REGS);
	assign hv_idx = hv_off[fee_reg_pkg::HV_IDX_W-1:0];

	assign resp.hit = (req.rd || req.wr) && own;
	assign resp.rdata = fee_reg_pkg::word_t'(setpoint[hv_idx]);

	always_ff @(posedge clk_40m) begin
		if (req.wr && own) begin
			setpoint[hv_idx] <= fee_reg_pkg::hv_code_t'(req.wdata);
		end
	end

	// **************************************************************************
	// DAC scan, lane k carries setpoint k*8 + dac_cnt
	// **************************************************************************

	always_ff @(posedge clk_40m) begin
		if (reset) begin
			for (int k = 0; k < fee_reg_pkg::HV_LANES; k++) begin
				dac_data[k] <= fee_reg_pkg::HV_IDLE_CODE;
			end
		end else begin
			for (int k = 0; k < fee_reg_pkg::HV_LANES; k++) begin
				dac_data[k] <= setpoint[k * fee_reg_pkg::HV_STEPS + int'(dac_cnt)];
			end
		end
	end

endmodule

// ==== source/fee_reg_pkg.sv ====
// Register map, data widths and reset values of the front-end slow-control block.
// Used by the register banks, the reply stage and the testbench through scoped names.
package fee_reg_pkg;

	typedef logic [7:0] addr_t;
	typedef logic [15:0] word_t;
	typedef logic [9:0] hv_code_t;
	typedef logic [9:0] adc_code_t;
	typedef logic [7:0] temp_th_t;

	// Bias bank geometry, four DAC lanes each scanning eight setpoints
	localparam int HV_REGS = 32;
	localparam int HV_LANES = 4;
	localparam int HV_STEPS = HV_REGS / HV_LANES;
	localparam int HV_IDX_W = $clog2(HV_REGS);

	// Monitor slots, in read order from ADDR_MON_BASE
	localparam int MON_REGS = 15;
	typedef logic [3:0] mon_idx_t;
	localparam mon_idx_t MON_T13 = 4'd0, MON_D4V2 = 4'd1, MON_D4V2C = 4'd2,
		MON_D3V3 = 4'd3, MON_D3V3C = 4'd4, MON_T15 = 4'd5, MON_AM6V = 4'd6,
		MON_AM6VC = 4'd7, MON_A6V = 4'd8, MON_A6VC = 4'd9, MON_T14 = 4'd10,
		MON_A3V3 = 4'd11, MON_A3V3C = 4'd12, MON_A13V5 = 4'd13, MON_A13V5C = 4'd14;

	// Register addresses
	localparam addr_t ADDR_REG_EN = 8'h01;
	localparam addr_t ADDR_LGSEN = 8'h02;
	localparam addr_t ADDR_FEE_ADDR = 8'h03;
	localparam addr_t ADDR_TOTI = 8'h05;
	localparam addr_t ADDR_MASK_LO = 8'h06;
	localparam addr_t ADDR_MASK_HI = 8'h07;
	localparam addr_t ADDR_ERR = 8'h0B;
	localparam addr_t ADDR_CNT_RESET = 8'h1B;
	localparam addr_t ADDR_HV_UPDATE = 8'h1E;
	localparam addr_t ADDR_ERR_CLR = 8'h1F;
	localparam addr_t ADDR_MON_BASE = 8'h50;
	localparam addr_t ADDR_HV_BASE = 8'h60;

	// Reset values
	localparam temp_th_t TOTI_DEFAULT = 8'd80;
	localparam temp_th_t THYST_OFFSET = 8'd5;
	localparam logic [2:0] REG_EN_DEFAULT = 3'd7;
	localparam logic LGSEN_DEFAULT = 1'b1;
	localparam hv_code_t HV_IDLE_CODE = 10'h3FF;
	localparam adc_code_t MON_DEFAULTS [MON_REGS] = '{
		10'h0A0, 10'h1D9, 10'h00C, 10'h1C2, 10'h011,
		10'h0A0, 10'h171, 10'h014, 10'h1E8, 10'h016,
		10'h0A0, 10'h1C2, 10'h014, 10'h1D1, 10'h00F
	};

endpackage

// ==== source/fee_reg_top.sv ====
// Slow-control register block of the front-end card. The sequencer feeds three
// register banks in parallel and the reply stage merges their answers.
`timescale 1ns/1ps

module fee_reg_top (
	input  logic                    clk_40m,
	input  logic                    reset,
	input  logic                    cmd_exec,
	input  logic                    cmd_rw,
	input  fee_reg_pkg::addr_t      cmd_addr,
	input  fee_reg_pkg::word_t      cmd_rx,
	output logic                    cmd_ack,
	output fee_reg_pkg::word_t      cmd_tx,
	output logic [2:0]              reg_en,
	output logic                    lgsen,
	output logic [4:0]              fee_addr,
	output fee_reg_pkg::temp_th_t   toti_h,
	output fee_reg_pkg::temp_th_t   thyst_h,
	output logic [31:0]             channel_mask,
	output logic                    cnt_reset_pulse,
	output logic                    hv_update,
	output fee_reg_pkg::word_t      err_fpga_cmd,
	output logic                    err_clr,
	input  logic [2:0]              dac_cnt,
	output fee_reg_pkg::hv_code_t   dac_data [fee_reg_pkg::HV_LANES],
	input  logic                    adc_read_finish,
	input  fee_reg_pkg::adc_code_t  adc_result,
	input  logic [3:0]              adc_cnt
);

	fee_cmd_pkg::cmd_req_t req;
	fee_cmd_pkg::bank_resp_t cfg_resp;
	fee_cmd_pkg::bank_resp_t hv_resp;
	fee_cmd_pkg::bank_resp_t mon_resp;

	fee_cmd_sequencer u_seq (.clk_40m, .reset, .cmd_exec, .cmd_rw, .cmd_addr, .cmd_rx,
		.cmd_ack, .req);

	fee_config_regs u_cfg (.clk_40m, .reset, .req, .resp(cfg_resp), .reg_en, .lgsen,
		.fee_addr, .toti_h, .thyst_h, .channel_mask, .cnt_reset_pulse, .hv_update);

	fee_hv_bank u_hv (.clk_40m, .reset, .req, .dac_cnt, .resp(hv_resp), .dac_data);

	fee_tvi_monitor u_mon (.clk_40m, .reset, .req, .adc_read_finish, .adc_result,
		.adc_cnt, .resp(mon_resp));

	fee_cmd_reply u_reply (.clk_40m, .reset, .req, .cfg_resp, .hv_resp, .mon_resp,
		.cmd_tx, .err_fpga_cmd, .err_clr);

endmodule

// ==== source/fee_tvi_monitor.sv ====
// Temperature, voltage and current monitor. Captures each ADC conversion on the
// rising edge of adc_read_finish and serves the results at ADDR_MON_BASE.
`timescale 1ns/1ps

module fee_tvi_monitor (
	input  logic                     clk_40m,
	input  logic                     reset,
	input  fee_cmd_pkg::cmd_req_t    req,
	input  logic                     adc_read_finish,
	input  fee_reg_pkg::adc_code_t   adc_result,
	input  logic [3:0]               adc_cnt,
	output fee_cmd_pkg::bank_resp_t  resp
);

	fee_reg_pkg::adc_code_t mon [fee_reg_pkg::MON_REGS];
	fee_reg_pkg::adc_code_t res_q;
	fee_reg_pkg::adc_code_t minuend;
	fee_reg_pkg::adc_code_t subtrahend;
	fee_reg_pkg::adc_code_t upd_val;
	fee_reg_pkg::mon_idx_t upd_idx;
	fee_reg_pkg::addr_t mon_off;
	logic [3:0] cnt_q;
	logic fin_q;
	logic upd;
	logic is_cur;

	always_ff @(posedge clk_40m) begin
		if (reset) begin
			fin_q <= 1'b0;
			upd <= 1'b0;
		end else begin
			fin_q <= adc_read_finish;
			upd <= adc_read_finish && !fin_q;
		end
	end

	// Conversion result and channel held from the finish edge
	always_ff @(posedge clk_40m) begin
		if (adc_read_finish && !fin_q) begin
			res_q <= adc_result;
			cnt_q <= adc_cnt;
		end
	end

	// Channel code to slot; currents are a voltage drop floored at zero
	always_comb begin
		is_cur = 1'b1;
		minuend = res_q;
		subtrahend = '0;
		case (cnt_q)
			4'h1: upd_idx = fee_reg_pkg::MON_T13;
			4'h2: upd_idx = fee_reg_pkg::MON_T14;
			4'h3: upd_idx = fee_reg_pkg::MON_T15;
			4'h4: upd_idx = fee_reg_pkg::MON_D4V2;
			4'h5: upd_idx = fee_reg_pkg::MON_A3V3;
			4'h6: upd_idx = fee_reg_pkg::MON_AM6V;
			4'hA: upd_idx = fee_reg_pkg::MON_D3V3;
			4'hB: upd_idx = fee_reg_pkg::MON_A13V5;
			4'hC: upd_idx = fee_reg_pkg::MON_A6V;
			4'h7: begin
				upd_idx = fee_reg_pkg::MON_D4V2C;
				minuend = mon[fee_reg_pkg::MON_D4V2];
				subtrahend = res_q;
			end
			4'h8: begin
				upd_idx = fee_reg_pkg::MON_A3V3C;
				minuend = mon[fee_reg_pkg::MON_A3V3];
				subtrahend = res_q;
			end
			// Negative rail reads the other way round
			4'h9: begin
				upd_idx = fee_reg_pkg::MON_AM6VC;
				subtrahend = mon[fee_reg_pkg::MON_AM6V];
			end
			4'hD: begin
				upd_idx = fee_reg_pkg::MON_D3V3C;
				minuend = mon[fee_reg_pkg::MON_D3V3];
				subtrahend = res_q;
			end
			4'hE: begin
				upd_idx = fee_reg_pkg::MON_A13V5C;
				minuend = mon[fee_reg_pkg::MON_A13V5];
				subtrahend = res_q;
			end
			default: begin
				upd_idx = fee_reg_pkg::MON_A6VC;
				minuend = mon[fee_reg_pkg::MON_A6V];
				subtrahend = res_q;
			end
		endcase
		if (cnt_q inside {4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hA, 4'hB, 4'hC}) begin
			is_cur = 1'b0;
		end
		if (!is_cur) begin
			upd_val = res_q;
		end else if (minuend > subtrahend) begin
			upd_val = minuend - subtrahend;
		end else begin
			upd_val = '0;
		end
	end

	always_ff @(posedge clk_40m) begin
		if (reset) begin
			mon <= fee_reg_pkg::MON_DEFAULTS;
		end else if (upd) begin
			mon[upd_idx] <= upd_val;
		end
	end

	// Readback, wrap below the base keeps the offset out of range
	assign mon_off = req.addr - fee_reg_pkg::ADDR_MON_BASE;
	assign resp.hit = req.rd && (mon_off < fee_reg_pkg::addr_t'(fee_reg_pkg::MON_REGS));
	assign resp.rdata = fee_reg_pkg::word_t'(mon[mon_off[3:0]]);

	a_cur_bound: assert property (@(posedge clk_40m) disable iff (reset)
		upd && is_cur |=> mon[$past(upd_idx)] <= $past(minuend));

endmodule

// ==== tb/tb_fee_reg.sv ====
// Testbench for the front-end slow-control register block. Issues host commands,
// steps the DAC scan and feeds ADC conversions; concurrent assertions compare the
// DUT against a small behavioral model kept in this file.
`timescale 1ns/1ps

module tb_fee_reg;

	localparam int ACK_LIMIT = 40;
	localparam fee_reg_pkg::addr_t CFG_ADDRS [6] = '{8'h01, 8'h02, 8'h03, 8'h05, 8'h06, 8'h07};

	logic clk_40m;
	logic reset;
	logic cmd_exec;
	logic cmd_rw;
	fee_reg_pkg::addr_t cmd_addr;
	fee_reg_pkg::word_t cmd_rx;
	logic cmd_ack;
	fee_reg_pkg::word_t cmd_tx;
	logic [2:0] reg_en;
	logic lgsen;
	logic [4:0] fee_addr;
	fee_reg_pkg::temp_th_t toti_h;
	fee_reg_pkg::temp_th_t thyst_h;
	logic [31:0] channel_mask;
	logic cnt_reset_pulse;
	logic hv_update;
	fee_reg_pkg::word_t err_fpga_cmd;
	logic err_clr;
	logic [2:0] dac_cnt;
	fee_reg_pkg::hv_code_t dac_data [fee_reg_pkg::HV_LANES];
	logic adc_read_finish;
	fee_reg_pkg::adc_code_t adc_result;
	logic [3:0] adc_cnt;

	// Model of the register contents
	logic [2:0] m_reg_en;
	logic m_lgsen;
	logic [4:0] m_fee_addr;
	fee_reg_pkg::temp_th_t m_toti;
	fee_reg_pkg::word_t m_mask_lo;
	fee_reg_pkg::word_t m_mask_hi;
	logic m_hv_upd;
	fee_reg_pkg::word_t m_err;
	fee_reg_pkg::word_t exp_tx;
	fee_reg_pkg::hv_code_t m_hv [fee_reg_pkg::HV_REGS];
	fee_reg_pkg::adc_code_t m_mon [fee_reg_pkg::MON_REGS];
	int m_pulses;
	int pulses_seen = 0;
	int m_clrs;
	int clrs_seen = 0;

	logic [15:0] lfsr;
	logic chk_reset;
	logic chk_dac;
	logic timed_out;
	string hang_reason;
	int errors;
	int cmd_count;
	int adc_count;

	fee_reg_top DUT (.clk_40m, .reset, .cmd_exec, .cmd_rw, .cmd_addr, .cmd_rx, .cmd_ack,
		.cmd_tx, .reg_en, .lgsen, .fee_addr, .toti_h, .thyst_h, .channel_mask,
		.cnt_reset_pulse, .hv_update, .err_fpga_cmd, .err_clr, .dac_cnt, .dac_data,
		.adc_read_finish, .adc_result, .adc_cnt);

	always #4 clk_40m = ~clk_40m;

	always @(posedge clk_40m) begin
		if (!reset && cnt_reset_pulse) begin
			pulses_seen <= pulses_seen + 1;
		end
		if (!reset && err_clr) begin
			clrs_seen <= clrs_seen + 1;
		end
	end

	// ************************************************************************
	// Checks
	// ************************************************************************

	a_ack_two: assert property (@(posedge clk_40m) disable iff (reset)
		$rose(cmd_ack) |-> cmd_ack ##1 cmd_ack ##1 !cmd_ack)
		else begin
			errors++;
			$display("error at %0t: cmd_ack did not last two cycles", $time);
		end

	a_reset_vals: assert property (@(posedge clk_40m)
		chk_reset |-> !cmd_ack && toti_h == 8'd80 && thyst_h == 8'd75 && reg_en == 3'd7
			&& lgsen && !hv_update && dac_data[0] == 10'h3FF && dac_data[1] == 10'h3FF
			&& dac_data[2] == 10'h3FF && dac_data[3] == 10'h3FF)
		else begin
			errors++;
			$display("error at %0t: outputs differ from reset values", $time);
		end

	a_readback: assert property (@(posedge clk_40m) cmd_ack |-> cmd_tx == exp_tx)
		else begin
			errors++;
			$display("error at %0t: cmd_tx %h, expected %h", $time, cmd_tx, exp_tx);
		end

	a_cfg: assert property (@(posedge clk_40m)
		cmd_ack |-> reg_en == m_reg_en && lgsen == m_lgsen && fee_addr == m_fee_addr
			&& toti_h == m_toti && channel_mask == {m_mask_hi, m_mask_lo}
			&& hv_update == m_hv_upd)
		else begin
			errors++;
			$display("error at %0t: configuration outputs differ from model", $time);
		end

	a_thyst: assert property (@(posedge clk_40m) cmd_ack |-> thyst_h == m_toti - 8'd5)
		else begin
			errors++;
			$display("error at %0t: thyst_h %0d with toti_h %0d", $time, thyst_h, m_toti);
		end

	a_err_word: assert property (@(posedge clk_40m) cmd_ack |-> err_fpga_cmd == m_err)
		else begin
			errors++;
			$display("error at %0t: err_fpga_cmd %h, expected %h", $time, err_fpga_cmd, m_err);
		end

	a_err_clr: assert property (@(posedge clk_40m) disable iff (reset)
		err_clr |-> err_fpga_cmd == 16'h0000)
		else begin
			errors++;
			$display("error at %0t: err_clr with error word still set", $time);
		end

	a_clr_count: assert property (@(posedge clk_40m) cmd_ack |-> clrs_seen == m_clrs)
		else begin
			errors++;
			$display("error at %0t: %0d error-clear pulses, expected %0d", $time,
				clrs_seen, m_clrs);
		end

	a_pulse_count: assert property (@(posedge clk_40m) cmd_ack |-> pulses_seen == m_pulses)
		else begin
			errors++;
			$display("error at %0t: %0d counter-reset pulses, expected %0d", $time,
				pulses_seen, m_pulses);
		end

	a_pulse_len: assert property (@(posedge clk_40m)
		!reset && cnt_reset_pulse |=> !cnt_reset_pulse)
		else begin
			errors++;
			$display("error at %0t: cnt_reset_pulse longer than one cycle", $time);
		end

	// Lane k shows setpoint k*8 + dac_cnt one cycle later
	for (genvar k = 0; k < fee_reg_pkg::HV_LANES; k++) begin : g_lane
		localparam logic [1:0] LANE = 2'(k);
		a_dac: assert property (@(posedge clk_40m)
			chk_dac |=> dac_data[k] == m_hv[{LANE, $past(dac_cnt)}])
			else begin
				errors++;
				$display("error at %0t: dac_data lane %0d is %h", $time, k, dac_data[k]);
			end
	end

	// ************************************************************************
	// Model and stimulus helpers
	// ************************************************************************

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic logic is_owned(input logic rw, input fee_reg_pkg::addr_t addr);
		if (addr inside {[8'h60:8'h7F]}) begin
			return 1'b1;
		end else if (rw) begin
			return addr inside {8'h01, 8'h02, 8'h03, 8'h05, 8'h06, 8'h07, 8'h0B, [8'h50:8'h5E]};
		end else begin
			return addr inside {8'h01, 8'h02, 8'h03, 8'h05, 8'h06, 8'h07, 8'h1B, 8'h1E, 8'h1F};
		end
	endfunction

	function automatic fee_reg_pkg::word_t model_read(input fee_reg_pkg::addr_t addr);
		fee_reg_pkg::word_t val;
		val = '0;
		if (addr inside {[8'h60:8'h7F]}) begin
			val = 16'(m_hv[addr[4:0]]);
		end else if (addr inside {[8'h50:8'h5E]}) begin
			val = 16'(m_mon[addr[3:0]]);
		end else begin
			case (addr)
				8'h01: val = {13'b0, m_reg_en};
				8'h02: val = {15'b0, m_lgsen};
				8'h03: val = {11'b0, m_fee_addr};
				8'h05: val = {8'b0, m_toti};
				8'h06: val = m_mask_lo;
				8'h07: val = m_mask_hi;
				8'h0B: val = m_err;
				default: val = '0;
			endcase
		end
		return val;
	endfunction

	function automatic void apply_cmd(input logic rw, input fee_reg_pkg::addr_t addr,
		input fee_reg_pkg::word_t data);
		if (!is_owned(rw, addr)) begin
			m_err = {rw, 1'b1, 6'b0, addr};
		end else if (rw) begin
			exp_tx = model_read(addr);
		end else begin
			case (addr)
				8'h01: m_reg_en = data[2:0];
				8'h02: m_lgsen = data[0];
				8'h03: m_fee_addr = data[4:0];
				8'h05: m_toti = data[7:0];
				8'h06: m_mask_lo = data;
				8'h07: m_mask_hi = data;
				8'h1B: m_pulses++;
				8'h1E: m_hv_upd = 1'b1;
				8'h1F: begin
					m_err = '0;
					m_clrs++;
				end
				default: m_hv[addr[4:0]] = data[9:0];
			endcase
		end
	endfunction

	function automatic fee_reg_pkg::adc_code_t floor_diff(input fee_reg_pkg::adc_code_t a,
		input fee_reg_pkg::adc_code_t b);
		return (a > b) ? a - b : '0;
	endfunction

	// Currents are the drop from their supply reading with the negative rail inverted
	function automatic void apply_adc(input logic [3:0] code, input fee_reg_pkg::adc_code_t r);
		case (code)
			4'h1: m_mon[fee_reg_pkg::MON_T13] = r;
			4'h2: m_mon[fee_reg_pkg::MON_T14] = r;
			4'h3: m_mon[fee_reg_pkg::MON_T15] = r;
			4'h4: m_mon[fee_reg_pkg::MON_D4V2] = r;
			4'h5: m_mon[fee_reg_pkg::MON_A3V3] = r;
			4'h6: m_mon[fee_reg_pkg::MON_AM6V] = r;
			4'hA: m_mon[fee_reg_pkg::MON_D3V3] = r;
			4'hB: m_mon[fee_reg_pkg::MON_A13V5] = r;
			4'hC: m_mon[fee_reg_pkg::MON_A6V] = r;
			4'h7: m_mon[fee_reg_pkg::MON_D4V2C] = floor_diff(m_mon[fee_reg_pkg::MON_D4V2], r);
			4'h8: m_mon[fee_reg_pkg::MON_A3V3C] = floor_diff(m_mon[fee_reg_pkg::MON_A3V3], r);
			4'h9: m_mon[fee_reg_pkg::MON_AM6VC] = floor_diff(r, m_mon[fee_reg_pkg::MON_AM6V]);
			4'hD: m_mon[fee_reg_pkg::MON_D3V3C] = floor_diff(m_mon[fee_reg_pkg::MON_D3V3], r);
			4'hE: m_mon[fee_reg_pkg::MON_A13V5C] = floor_diff(m_mon[fee_reg_pkg::MON_A13V5], r);
			default: m_mon[fee_reg_pkg::MON_A6VC] = floor_diff(m_mon[fee_reg_pkg::MON_A6V], r);
		endcase
	endfunction

	task automatic wait_ack(input logic level);
		int waited;
		waited = 0;
		while (cmd_ack !== level && waited < ACK_LIMIT) begin
			@(negedge clk_40m);
			waited++;
		end
		if (cmd_ack !== level) begin
			if (level) begin
				hang_reason = "cmd_ack never went high after cmd_exec";
			end else begin
				hang_reason = "cmd_ack stayed high";
			end
			timed_out = 1'b1;
		end
	endtask

	task automatic run_cmd(input logic rw, input fee_reg_pkg::addr_t addr,
		input fee_reg_pkg::word_t data);
		apply_cmd(rw, addr, data);
		@(negedge clk_40m);
		cmd_rw = rw;
		cmd_addr = addr;
		cmd_rx = data;
		cmd_exec = 1'b1;
		wait_ack(1'b1);
		cmd_exec = 1'b0;
		wait_ack(1'b0);
		cmd_count++;
	endtask

	task automatic write_reg(input fee_reg_pkg::addr_t addr, input fee_reg_pkg::word_t data);
		run_cmd(1'b0, addr, data);
	endtask

	task automatic read_reg(input fee_reg_pkg::addr_t addr);
		run_cmd(1'b1, addr, 16'h0000);
	endtask

	task automatic adc_sample(input logic [3:0] code, input fee_reg_pkg::adc_code_t value);
		apply_adc(code, value);
		@(negedge clk_40m);
		adc_cnt = code;
		adc_result = value;
		adc_read_finish = 1'b1;
		@(negedge clk_40m);
		adc_read_finish = 1'b0;
		repeat (3) @(negedge clk_40m);
		adc_count++;
	endtask

	initial begin
		@(posedge timed_out);
		$display("timeout: %s", hang_reason);
		$display("summary: %0d commands, %0d ADC samples, %0d errors", cmd_count,
			adc_count, errors);
		$display("=== FAIL ===");
		$finish;
	end

	// ************************************************************************
	// Test sequence
	// ************************************************************************

	initial begin
		clk_40m = 1'b0;
		reset = 1'b1;
		cmd_exec = 1'b0;
		cmd_rw = 1'b0;
		cmd_addr = '0;
		cmd_rx = '0;
		dac_cnt = '0;
		adc_read_finish = 1'b0;
		adc_result = '0;
		adc_cnt = '0;
		lfsr = 16'd51852;
		chk_reset = 1'b0;
		chk_dac = 1'b0;
		timed_out = 1'b0;
		errors = 0;
		cmd_count = 0;
		adc_count = 0;
		m_reg_en = 3'd7;
		m_lgsen = 1'b1;
		m_fee_addr = '0;
		m_toti = 8'd80;
		m_mask_lo = '0;
		m_mask_hi = '0;
		m_hv_upd = 1'b0;
		m_err = '0;
		exp_tx = '0;
		m_clrs = 0;
		// The pulse leaving reset counts as the first one
		m_pulses = 1;
		for (int i = 0; i < fee_reg_pkg::MON_REGS; i++) begin
			m_mon[i] = fee_reg_pkg::MON_DEFAULTS[i];
		end

		repeat (5) @(negedge clk_40m);
		reset = 1'b0;
		chk_reset = 1'b1;
		@(negedge clk_40m);
		chk_reset = 1'b0;
		for (int i = 0; i < 6; i++) begin
			read_reg(CFG_ADDRS[i]);
		end

		// Configuration writes and readback
		for (int r = 0; r < 4; r++) begin
			for (int i = 0; i < 6; i++) begin
				write_reg(CFG_ADDRS[i], rand_bits(16));
			end
			for (int i = 0; i < 6; i++) begin
				read_reg(CFG_ADDRS[i]);
			end
		end

		// Bias bank and DAC scan
		for (int i = 0; i < fee_reg_pkg::HV_REGS; i++) begin
			write_reg(8'h60 + 8'(i), rand_bits(16));
		end
		for (int i = 0; i < fee_reg_pkg::HV_REGS; i++) begin
			read_reg(8'h60 + 8'(i));
		end
		for (int i = 0; i < 24; i++) begin
			@(negedge clk_40m);
			chk_dac = 1'b1;
			if (i < 8) begin
				dac_cnt = 3'(i);
			end else begin
				dac_cnt = 3'(rand_bits(3));
			end
		end
		@(negedge clk_40m);
		chk_dac = 1'b0;

		// Monitor with every code once and then a random mix
		for (int i = 0; i < 16; i++) begin
			adc_sample(4'(i), fee_reg_pkg::adc_code_t'(rand_bits(10)));
		end
		for (int i = 0; i < 40; i++) begin
			adc_sample(4'(rand_bits(4)), fee_reg_pkg::adc_code_t'(rand_bits(10)));
		end
		for (int i = 0; i < fee_reg_pkg::MON_REGS; i++) begin
			read_reg(8'h50 + 8'(i));
		end

		// Unowned addresses and the error clear
		read_reg(8'h00);
		write_reg(8'h0B, 16'h1234);
		read_reg(8'h0B);
		read_reg(8'h1B);
		write_reg(8'h50, 16'h00FF);
		read_reg(8'h5F);
		read_reg(8'h9A);
		read_reg(8'h0B);
		write_reg(8'h1F, 16'h0000);
		read_reg(8'h0B);

		// Control pulses and the sticky HV update flag
		write_reg(8'h1B, 16'h0001);
		write_reg(8'h1B, 16'h0001);
		write_reg(8'h1E, 16'h0001);
		read_reg(8'h01);
		write_reg(8'h1E, 16'h0000);

		for (int i = 0; i < 24; i++) begin
			run_cmd(rand_bits(1) != 16'h0000, 8'(rand_bits(8)), rand_bits(16));
		end

		@(negedge clk_40m);
		$display("summary: %0d commands, %0d ADC samples, %0d errors", cmd_count,
			adc_count, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
source/fee_reg_pkg.sv
source/fee_cmd_pkg.sv
source/fee_cmd_sequencer.sv
source/fee_config_regs.sv
source/fee_hv_bank.sv
source/fee_tvi_monitor.sv
source/fee_cmd_reply.sv
source/fee_reg_top.sv
tb/tb_fee_reg.sv
